//--- source/refl_pkg.sv
`default_nettype none

package refl_pkg;

  // one DDR half, rising or falling edge byte
  typedef logic [7:0]  adc_half_t;

  // merged ADC sample
  typedef logic [15:0] sample_t;

  // four samples per external FIFO word
  typedef logic [63:0] fifo_word_t;

  // register port
  typedef logic [2:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  localparam int SAMPLES_PER_WORD = 4;

  // over-range hold time in clk cycles
  localparam int OR_STRETCH = 16;

  // register map
  localparam reg_addr_t ADDR_REFLENGTH  = 3'd0;
  localparam reg_addr_t ADDR_RUN        = 3'd1;
  localparam reg_addr_t ADDR_STROBE_LEN = 3'd2;
  localparam reg_addr_t ADDR_SOA_LEN    = 3'd3;
  localparam reg_addr_t ADDR_FIFO_CTRL  = 3'd4;
  localparam reg_addr_t ADDR_WORD_COUNT = 3'd5;

  // power-up configuration, roughly a 60 km trace
  localparam reg_data_t RST_REFLENGTH  = 32'd60000;
  localparam reg_data_t RST_STROBE_LEN = 32'd630;
  localparam reg_data_t RST_SOA_LEN    = 32'd8;

  // pulse timing configuration, reflength is period minus one
  typedef struct packed {
    reg_data_t reflength;
    reg_data_t strobe_len;
    reg_data_t soa_len;
    logic      run;
  } pulse_cfg_t;

  // packer status back to the register file
  typedef struct packed {
    logic      overflow;
    reg_data_t word_count;
  } pack_status_t;

endpackage

`default_nettype wire

//--- source/adc_ddr_merge.sv
`default_nettype none

module adc_ddr_merge
  import refl_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire adc_half_t i_adc_p,
  input  wire adc_half_t i_adc_n,
  input  wire logic      i_or_p,
  input  wire logic      i_or_n,
  output sample_t        o_sample,
  output logic           o_overrange
);

  // first stage, DDR halves as they come from the IOB
  adc_half_t adc_p_q;
  adc_half_t adc_n_q;

  // second stage, falling byte goes to the even sample bits
  adc_half_t dmux_even;
  adc_half_t dmux_odd;

  logic       or_p_q;
  logic       or_n_q;
  // bit 4 set while the flag is being held
  logic [4:0] or_cnt;

  always_ff @(posedge clk)
  begin
    adc_p_q   <= i_adc_p;
    adc_n_q   <= i_adc_n;
    dmux_even <= adc_n_q;
    dmux_odd  <= adc_p_q;
    // interleave into the sample, rising bit above falling bit
    for (int k = 0; k < $bits(adc_half_t); k++)
    begin
      o_sample[2*k+1] <= dmux_odd[k];
      o_sample[2*k]   <= dmux_even[k];
    end
  end

  // over-range stretch
  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      or_p_q      <= 1'b0;
      or_n_q      <= 1'b0;
      or_cnt      <= '0;
      o_overrange <= 1'b0;
    end
    else
    begin
      or_p_q <= i_or_p;
      or_n_q <= i_or_n;
      // a new pulse restarts the hold window
      if (or_p_q || or_n_q)
        or_cnt <= 5'(OR_STRETCH);
      else if (or_cnt[4])
        or_cnt <= or_cnt + 5'd1;
      o_overrange <= or_cnt[4];
    end
  end

endmodule

`default_nettype wire

//--- source/refl_ctrl_regs.sv
`default_nettype none

module refl_ctrl_regs
  import refl_pkg::*;
(
  input  wire logic         clk,
  input  wire logic         reset,
  input  wire logic         i_wr_en,
  input  wire reg_addr_t    i_wr_addr,
  input  wire reg_data_t    i_wr_data,
  input  wire reg_addr_t    i_rd_addr,
  input  wire pack_status_t i_status,
  output reg_data_t         o_rd_data,
  output pulse_cfg_t        o_cfg,
  output logic              o_fifo_reset
);

  pulse_cfg_t cfg_q;
  pulse_cfg_t cfg_nxt;
  reg_data_t  rd_nxt;

  // write decode
  always_comb
  begin
    cfg_nxt = cfg_q;
    if (i_wr_en)
    begin
      case (i_wr_addr)
        ADDR_REFLENGTH:  cfg_nxt.reflength  = i_wr_data;
        // any nonzero value starts acquisition
        ADDR_RUN:        cfg_nxt.run        = |i_wr_data;
        ADDR_STROBE_LEN: cfg_nxt.strobe_len = i_wr_data;
        ADDR_SOA_LEN:    cfg_nxt.soa_len    = i_wr_data;
        default:         cfg_nxt            = cfg_q;
      endcase
    end
  end

  // read mux works on the next value
  // so a write is visible one cycle later
  always_comb
  begin
    case (i_rd_addr)
      ADDR_REFLENGTH:  rd_nxt = cfg_nxt.reflength;
      ADDR_RUN:        rd_nxt = reg_data_t'(cfg_nxt.run);
      ADDR_STROBE_LEN: rd_nxt = cfg_nxt.strobe_len;
      ADDR_SOA_LEN:    rd_nxt = cfg_nxt.soa_len;
      // FIFO control reads back the sticky overflow
      ADDR_FIFO_CTRL:  rd_nxt = reg_data_t'(i_status.overflow);
      ADDR_WORD_COUNT: rd_nxt = i_status.word_count;
      default:         rd_nxt = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      cfg_q.reflength  <= RST_REFLENGTH;
      cfg_q.strobe_len <= RST_STROBE_LEN;
      cfg_q.soa_len    <= RST_SOA_LEN;
      cfg_q.run        <= 1'b0;
      o_rd_data        <= '0;
      o_fifo_reset     <= 1'b0;
    end
    else
    begin
      cfg_q     <= cfg_nxt;
      o_rd_data <= rd_nxt;
      // single-cycle FIFO reset on any write to FIFO_CTRL
      o_fifo_reset <= i_wr_en && (i_wr_addr == ADDR_FIFO_CTRL);
    end
  end

  assign o_cfg = cfg_q;

endmodule

`default_nettype wire

//--- source/pulse_timer.sv
`default_nettype none

module pulse_timer
  import refl_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire pulse_cfg_t i_cfg,
  output logic            o_strobe,
  output logic            o_soa,
  output logic            o_period_mark
);

  // position inside the reflectogram period
  reg_data_t period_cnt;

  // cycles since the last wrap, saturate past the length
  reg_data_t strobe_cnt;
  reg_data_t soa_cnt;

  logic period_end;

  assign period_end = (period_cnt == i_cfg.reflength);

  // last cycle of the period
  assign o_period_mark = i_cfg.run && period_end;

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      period_cnt <= '0;
      strobe_cnt <= '0;
      soa_cnt    <= '0;
      o_strobe   <= 1'b0;
      o_soa      <= 1'b0;
    end
    else if (!i_cfg.run)
    begin
      // idle, hold everything cleared
      period_cnt <= '0;
      strobe_cnt <= '0;
      soa_cnt    <= '0;
      o_strobe   <= 1'b0;
      o_soa      <= 1'b0;
    end
    else if (period_end)
    begin
      // wrap and fire both pulses
      period_cnt <= '0;
      strobe_cnt <= '0;
      soa_cnt    <= '0;
      o_strobe   <= 1'b1;
      o_soa      <= 1'b1;
    end
    else
    begin
      period_cnt <= period_cnt + 1'b1;

      if (strobe_cnt <= i_cfg.strobe_len)
      begin
        strobe_cnt <= strobe_cnt + 1'b1;
        o_strobe   <= 1'b1;
      end
      else
        o_strobe <= 1'b0;

      // SOA gate, usually much shorter than the laser strobe
      if (soa_cnt <= i_cfg.soa_len)
      begin
        soa_cnt <= soa_cnt + 1'b1;
        o_soa   <= 1'b1;
      end
      else
        o_soa <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- source/sample_packer.sv
`default_nettype none

module sample_packer
  import refl_pkg::*;
(
  input  wire logic    clk,
  input  wire logic    reset,
  input  wire logic    i_run,
  input  wire logic    i_period_mark,
  input  wire sample_t i_sample,
  input  wire logic    i_fifo_full,
  output logic         o_fifo_wr_en,
  output fifo_word_t   o_fifo_data,
  output pack_status_t o_status
);

  // slot of the next capture
  logic [1:0]   phase;
  logic         capture;
  logic         last_slot;
  pack_status_t status_q;

  // no capture on the period mark cycle
  assign capture   = i_run && !i_period_mark;
  assign last_slot = (phase == 2'(SAMPLES_PER_WORD - 1));

  // slot order is top quarter first, then upwards from the bottom
  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      case (phase)
        2'd0:    o_fifo_data[63:48] <= i_sample;
        2'd1:    o_fifo_data[15:0]  <= i_sample;
        2'd2:    o_fifo_data[31:16] <= i_sample;
        default: o_fifo_data[47:32] <= i_sample;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset)
    begin
      phase        <= '0;
      o_fifo_wr_en <= 1'b0;
      status_q     <= '0;
    end
    else
    begin
      o_fifo_wr_en <= 1'b0;
      if (!i_run)
        phase <= '0;
      else if (capture)
      begin
        phase <= phase + 2'd1;
        if (last_slot)
        begin
          // word is counted even when it gets dropped
          status_q.word_count <= status_q.word_count + 1'b1;
          o_fifo_wr_en        <= !i_fifo_full;
          if (i_fifo_full)
            status_q.overflow <= 1'b1;
        end
      end
    end
  end

  assign o_status = status_q;

endmodule

`default_nettype wire

//--- source/refl_top.sv
`default_nettype none

module refl_top
  import refl_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire adc_half_t i_adc_p,
  input  wire adc_half_t i_adc_n,
  input  wire logic      i_or_p,
  input  wire logic      i_or_n,
  input  wire logic      i_wr_en,
  input  wire reg_addr_t i_wr_addr,
  input  wire reg_data_t i_wr_data,
  input  wire reg_addr_t i_rd_addr,
  output reg_data_t      o_rd_data,
  output logic           o_fifo_wr_en,
  output fifo_word_t     o_fifo_data,
  output logic           o_fifo_reset,
  input  wire logic      i_fifo_full,
  output logic           o_strobe,
  output logic           o_soa,
  output logic           o_overrange
);

  sample_t      sample;
  pulse_cfg_t   cfg;
  logic         period_mark;
  pack_status_t status;

  // stage one, DDR merge
  adc_ddr_merge u_merge (
    .clk         (clk),
    .reset       (reset),
    .i_adc_p     (i_adc_p),
    .i_adc_n     (i_adc_n),
    .i_or_p      (i_or_p),
    .i_or_n      (i_or_n),
    .o_sample    (sample),
    .o_overrange (o_overrange)
  );

  refl_ctrl_regs u_regs (
    .clk          (clk),
    .reset        (reset),
    .i_wr_en      (i_wr_en),
    .i_wr_addr    (i_wr_addr),
    .i_wr_data    (i_wr_data),
    .i_rd_addr    (i_rd_addr),
    .i_status     (status),
    .o_rd_data    (o_rd_data),
    .o_cfg        (cfg),
    .o_fifo_reset (o_fifo_reset)
  );

  pulse_timer u_timer (
    .clk           (clk),
    .reset         (reset),
    .i_cfg         (cfg),
    .o_strobe      (o_strobe),
    .o_soa         (o_soa),
    .o_period_mark (period_mark)
  );

  // stage two, word packing into the external FIFO
  sample_packer u_packer (
    .clk           (clk),
    .reset         (reset),
    .i_run         (cfg.run),
    .i_period_mark (period_mark),
    .i_sample      (sample),
    .i_fifo_full   (i_fifo_full),
    .o_fifo_wr_en  (o_fifo_wr_en),
    .o_fifo_data   (o_fifo_data),
    .o_status      (status)
  );

endmodule

`default_nettype wire

//--- tb/refl_checker.sv
`default_nettype none

module refl_checker
  import refl_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       reset,
  input  wire logic       wr_en,
  input  wire reg_addr_t  wr_addr,
  input  wire reg_data_t  wr_data,
  input  wire logic       fifo_full,
  input  wire logic       or_in,
  input  wire reg_data_t  rd_data,
  input  wire logic       fifo_wr_en,
  input  wire fifo_word_t fifo_data,
  input  wire logic       fifo_reset,
  input  wire logic       strobe,
  input  wire logic       soa,
  input  wire logic       overrange,
  input  wire logic       rd_check,
  input  wire logic       rd_model,
  input  wire reg_data_t  rd_exp,
  input  wire logic       test_done,
  input  wire reg_data_t  test_id,
  output int              err_count,
  output int              check_count
);

  // reference model state for the register map, timer and packer
  pulse_cfg_t cfg;
  reg_data_t  pcnt;
  reg_data_t  scnt;
  reg_data_t  acnt;
  reg_data_t  words;
  reg_data_t  writes;
  logic [1:0] phase;
  logic       ovf;
  logic       exp_wr;
  logic       exp_rst;
  logic       exp_str;
  logic       exp_soa;
  int         test_start_errs;
  int         or_len;
  int         or_since;
  logic       or_prev;

  initial
  begin
    err_count       = 0;
    check_count     = 0;
    test_start_errs = 0;
  end

  task automatic compare_bit(input string name, input logic exp, input logic got);
    check_count++;
    if (got !== exp)
    begin
      $display("CHECK FAILED t=%0t %s expected=%b actual=%b", $time, name, exp, got);
      err_count++;
    end
  endtask

  task automatic value_check(input string name, input reg_data_t exp, input reg_data_t got);
    check_count++;
    if (got !== exp)
    begin
      $display("CHECK FAILED t=%0t %s expected=%0h actual=%0h", $time, name, exp, got);
      err_count++;
    end
  endtask

  // fields in capture order step by one, or by two once across a mark
  function automatic logic word_ok(input fifo_word_t w);
    sample_t f [4];
    sample_t d;
    int      jumps;
    f[0] = w[63:48];
    f[1] = w[15:0];
    f[2] = w[31:16];
    f[3] = w[47:32];
    jumps = 0;
    word_ok = 1'b1;
    for (int i = 0; i < 3; i++)
    begin
      d = f[i+1] - f[i];
      if (d == 16'd2)
        jumps++;
      else if (d != 16'd1)
        word_ok = 1'b0;
    end
    if (jumps > 1)
      word_ok = 1'b0;
  endfunction

  always @(posedge clk)
  begin : model
    logic mark;
    if (!reset)
    begin
      cfg.reflength  = RST_REFLENGTH;
      cfg.strobe_len = RST_STROBE_LEN;
      cfg.soa_len    = RST_SOA_LEN;
      cfg.run        = 1'b0;
      pcnt = '0;
      scnt = '0;
      acnt = '0;
      words = '0;
      writes = '0;
      phase = '0;
      ovf = 1'b0;
      exp_wr = 1'b0;
      exp_rst = 1'b0;
      exp_str = 1'b0;
      exp_soa = 1'b0;
      or_len = 0;
      or_since = 100;
      or_prev = 1'b0;
    end
    else
    begin
      compare_bit("o_fifo_wr_en", exp_wr, fifo_wr_en);
      compare_bit("o_fifo_reset", exp_rst, fifo_reset);
      compare_bit("o_strobe", exp_str, strobe);
      compare_bit("o_soa", exp_soa, soa);
      if (fifo_wr_en)
      begin
        writes++;
        if (!word_ok(fifo_data))
        begin
          $display("t=%0t FIFO word %h does not hold consecutive samples", $time, fifo_data);
          err_count++;
        end
      end
      if (rd_check)
      begin
        if (rd_model)
        begin
          value_check("o_rd_data (word count)", words, rd_data);
          if (!ovf && writes != words)
          begin
            $display("t=%0t %0d FIFO writes seen but %0d words counted", $time, writes, words);
            err_count++;
          end
        end
        else
          value_check("o_rd_data", rd_exp, rd_data);
      end

      // over-range hold window
      if (or_in)
        or_since = 0;
      else if (or_since < 100)
        or_since++;
      if (overrange)
        or_len++;
      if (overrange && !or_prev && or_since > 4)
      begin
        $display("t=%0t o_overrange rose without a recent over-range pulse", $time);
        err_count++;
      end
      if (or_since == 4 && !overrange)
      begin
        $display("t=%0t o_overrange did not rise after an over-range pulse", $time);
        err_count++;
      end
      if (or_since == OR_STRETCH + 4 && overrange)
      begin
        $display("t=%0t o_overrange still high after the hold window", $time);
        err_count++;
      end
      if (!overrange && or_prev)
      begin
        value_check("o_overrange high cycles", OR_STRETCH, or_len);
        or_len = 0;
      end
      or_prev = overrange;

      // timer and packer step with the config before this edge
      mark = cfg.run && (pcnt == cfg.reflength);
      exp_wr = 1'b0;
      if (!cfg.run)
      begin
        pcnt = '0;
        scnt = '0;
        acnt = '0;
        phase = '0;
        exp_str = 1'b0;
        exp_soa = 1'b0;
      end
      else if (mark)
      begin
        pcnt = '0;
        scnt = '0;
        acnt = '0;
        exp_str = 1'b1;
        exp_soa = 1'b1;
      end
      else
      begin
        pcnt++;
        // pulse lengths count from the period start
        exp_str = (scnt <= cfg.strobe_len);
        if (exp_str)
          scnt++;
        exp_soa = (acnt <= cfg.soa_len);
        if (exp_soa)
          acnt++;
        if (phase == 2'd3)
        begin
          words++;
          if (fifo_full)
            ovf = 1'b1;
          else
            exp_wr = 1'b1;
        end
        phase = phase + 2'd1;
      end

      exp_rst = wr_en && (wr_addr == ADDR_FIFO_CTRL);
      if (wr_en)
      begin
        case (wr_addr)
          ADDR_REFLENGTH:  cfg.reflength = wr_data;
          ADDR_RUN:        cfg.run = |wr_data;
          ADDR_STROBE_LEN: cfg.strobe_len = wr_data;
          ADDR_SOA_LEN:    cfg.soa_len = wr_data;
          default:         cfg.run = cfg.run;
        endcase
      end

      if (test_done)
      begin
        $display("test %0d finished with %0d errors", test_id, err_count - test_start_errs);
        test_start_errs = err_count;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/refl_assertions.sv
`default_nettype none

module refl_assertions (
  input wire logic clk,
  input wire logic reset,
  input wire logic i_fifo_full,
  input wire logic o_fifo_wr_en,
  input wire logic o_fifo_reset,
  input wire logic o_strobe,
  input wire logic o_soa
);

  // a word completed while full must be dropped
  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (!reset) o_fifo_wr_en |-> !$past(i_fifo_full))
    else $error("FIFO written although full was high at the fourth capture");

  a_fifo_reset_single: assert property (
    @(posedge clk) disable iff (!reset) o_fifo_reset |=> !o_fifo_reset)
    else $error("FIFO reset lasted longer than one cycle");

  a_pulses_low_in_reset: assert property (
    @(posedge clk) !reset |=> (!o_strobe && !o_soa))
    else $error("strobe or SOA gate high during reset");

endmodule

bind refl_top refl_assertions u_assertions (
  .clk          (clk),
  .reset        (reset),
  .i_fifo_full  (i_fifo_full),
  .o_fifo_wr_en (o_fifo_wr_en),
  .o_fifo_reset (o_fifo_reset),
  .o_strobe     (o_strobe),
  .o_soa        (o_soa)
);

`default_nettype wire

//--- tb/refl_tb.sv
`default_nettype none

module refl_tb
  import refl_pkg::*;
();

  logic       clk;
  logic       reset;
  adc_half_t  i_adc_p;
  adc_half_t  i_adc_n;
  logic       i_or_p;
  logic       i_or_n;
  logic       i_wr_en;
  reg_addr_t  i_wr_addr;
  reg_data_t  i_wr_data;
  reg_addr_t  i_rd_addr;
  logic       i_fifo_full;
  reg_data_t  o_rd_data;
  logic       o_fifo_wr_en;
  fifo_word_t o_fifo_data;
  logic       o_fifo_reset;
  logic       o_strobe;
  logic       o_soa;
  logic       o_overrange;

  // every merged sample is this running count
  sample_t    sample_cnt;
  reg_data_t  stim [0:255];
  int         limit_cycles;
  int         errs;
  int         checks;
  int         tests;
  logic       bad_data;
  logic       rd_check;
  logic       rd_model;
  reg_data_t  rd_exp;
  logic       test_done;
  reg_data_t  test_id;

  refl_top uut (.*);

  refl_checker u_checker (
    .clk (clk), .reset (reset), .wr_en (i_wr_en), .wr_addr (i_wr_addr),
    .wr_data (i_wr_data), .fifo_full (i_fifo_full), .or_in (i_or_p | i_or_n),
    .rd_data (o_rd_data), .fifo_wr_en (o_fifo_wr_en), .fifo_data (o_fifo_data),
    .fifo_reset (o_fifo_reset), .strobe (o_strobe), .soa (o_soa),
    .overrange (o_overrange), .rd_check (rd_check), .rd_model (rd_model),
    .rd_exp (rd_exp), .test_done (test_done), .test_id (test_id),
    .err_count (errs), .check_count (checks)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // split the count into DDR halves, odd bits on the rising byte
  always @(posedge clk)
  begin
    sample_cnt <= sample_cnt + 16'd1;
    for (int k = 0; k < 8; k++)
    begin
      i_adc_p[k] <= sample_cnt[2*k+1];
      i_adc_n[k] <= sample_cnt[2*k];
    end
  end

  initial
  begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not finish", limit_cycles);
    $display("Errors found");
    $finish;
  end

  task automatic run_command(input reg_data_t op, input reg_data_t a, input reg_data_t b);
    case (op)
      32'd1:
      begin
        i_wr_en   <= 1'b1;
        i_wr_addr <= a[2:0];
        i_wr_data <= b;
        @(posedge clk);
        i_wr_en <= 1'b0;
      end
      32'd2, 32'd6:
      begin
        i_rd_addr <= a[2:0];
        @(posedge clk);
        rd_check <= 1'b1;
        rd_model <= (op == 32'd6);
        rd_exp   <= b;
        @(posedge clk);
        rd_check <= 1'b0;
      end
      32'd3:
        repeat (a) @(posedge clk);
      32'd4:
      begin
        i_fifo_full <= a[0];
        @(posedge clk);
      end
      32'd5:
      begin
        if (a[0])
          i_or_n <= 1'b1;
        else
          i_or_p <= 1'b1;
        @(posedge clk);
        i_or_p <= 1'b0;
        i_or_n <= 1'b0;
      end
      default:
      begin
        $display("unknown opcode %0d in the test data", op);
        bad_data = 1'b1;
      end
    endcase
  endtask

  initial
  begin : main
    int idx;
    int total;
    reset = 1'b0;
    sample_cnt = '0;
    i_adc_p = '0;
    i_adc_n = '0;
    i_or_p = 1'b0;
    i_or_n = 1'b0;
    i_wr_en = 1'b0;
    i_wr_addr = '0;
    i_wr_data = '0;
    i_rd_addr = '0;
    i_fifo_full = 1'b0;
    rd_check = 1'b0;
    rd_model = 1'b0;
    rd_exp = '0;
    test_done = 1'b0;
    test_id = '0;
    bad_data = 1'b0;
    tests = 0;
    limit_cycles = 0;
    $readmemh("tb/refl_testdata.txt", stim);

    // budget is all run lengths plus a few cycles per command
    total = 16;
    idx = 0;
    while (stim[idx+1] != 0)
    begin
      if (stim[idx+1] == 32'd3)
        total += int'(stim[idx+2]);
      total += 8;
      idx += 4;
    end
    limit_cycles = total + 200;

    repeat (16) @(posedge clk);
    reset <= 1'b1;
    @(posedge clk);

    idx = 0;
    while (stim[idx+1] != 0)
    begin
      test_id <= stim[idx];
      run_command(stim[idx+1], stim[idx+2], stim[idx+3]);
      if (stim[idx+4] != stim[idx])
      begin
        test_done <= 1'b1;
        @(posedge clk);
        test_done <= 1'b0;
        tests++;
      end
      idx += 4;
    end
    repeat (4) @(posedge clk);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errs);
    if (errs == 0 && !bad_data)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/refl_testdata.txt
// columns: test, opcode (1 write, 2 read, 3 run cycles, 4 full level, 5 over-range, 6 word count)
// then operand a (address, cycles, level or half) and operand b (data or expected), all hex
1 2 0 EA60
1 2 1 0
1 2 2 276
1 2 3 8
1 2 4 0
1 2 5 0
2 1 0 1234
2 2 0 1234
2 1 1 5
2 2 1 1
2 1 1 0
2 2 1 0
2 1 2 7
2 2 2 7
2 1 4 1
2 3 4 0
2 2 4 0
3 1 0 13
3 1 2 5
3 1 3 2
3 1 1 1
3 3 64 0
3 1 1 0
3 3 14 0
4 1 1 1
4 3 C8 0
4 1 1 0
4 3 A 0
4 6 5 0
5 4 1 0
5 1 1 1
5 3 64 0
5 1 1 0
5 4 0 0
5 3 A 0
5 2 4 1
5 6 5 0
6 5 0 0
6 3 1E 0
6 5 1 0
6 3 1E 0
0 0 0 0

//--- vlog.f
source/refl_pkg.sv
source/adc_ddr_merge.sv
source/refl_ctrl_regs.sv
source/pulse_timer.sv
source/sample_packer.sv
source/refl_top.sv
tb/refl_checker.sv
tb/refl_assertions.sv
tb/refl_tb.sv

//--- run.sh
#!/bin/bash
# build and run the testbench with Verilator, fail if the log reports errors
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module refl_tb -f vlog.f \
  -o refl_sim > build.log 2>&1 \
  && ./obj_dir/refl_sim > sim.log 2>&1 \
  || echo "Errors found" >> sim.log
cat sim.log
grep -q "Errors found" sim.log && { echo "simulation FAILED"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
